// ==== build.f ====
+incdir+testbench
logic/fp_alu_pkg.sv
logic/fp_compare.sv
logic/fp_add_sub.sv
logic/fp_mul.sv
logic/fp_alu_ctrl.sv
logic/fp_alu_top.sv
testbench/tb_fp_alu.sv

// ==== logic/fp_add_sub.sv ====
module fp_add_sub #(
    parameter int sig_width = fp_alu_pkg::sig_w
) (
    input  fp_alu_pkg::fp_word_t a,
    input  fp_alu_pkg::fp_word_t b,
    input  logic                 subtract,
    output fp_alu_pkg::fp_word_t sum_result
);

    localparam int fw = 2 * sig_width;            // alignment field width
    localparam int lw = $clog2(fw + 1);
    localparam int ew = fp_alu_pkg::exp_w;
    localparam int xw = ew + 1;
    localparam int nf = fp_alu_pkg::frac_w;
    localparam int up = fw - nf - 1;              // moves the hidden one to the field msb

    fp_alu_pkg::fp_word_t b_eff;
    fp_alu_pkg::fp_word_t big;
    fp_alu_pkg::fp_word_t small_op;
    logic                 a_zero;
    logic                 b_zero;
    logic [ew-1:0]        exp_diff;
    logic [fw-1:0]        big_field;
    logic [fw-1:0]        small_field;
    logic [fw:0]          mag_sum;                // extra bit catches the carry
    logic [lw-1:0]        lzc;
    logic [fw-1:0]        norm;
    logic [xw-1:0]        exp_norm;
    logic [nf-1:0]        frac_norm;
    logic                 underflow;

    assign b_eff  = {b.sign ^ subtract, b.exp, b.frac};
    assign a_zero = (a.exp == '0);
    assign b_zero = (b.exp == '0);

    // larger magnitude first and it sets the sign
    always_comb begin
        if (b_zero || (!a_zero && {a.exp, a.frac} >= {b.exp, b.frac})) begin
            big      = a;
            small_op = b_eff;
        end else begin
            big      = b_eff;
            small_op = a;
        end
    end

    assign exp_diff    = big.exp - small_op.exp;
    assign big_field   = (big.exp == '0) ? '0 : fw'({1'b1, big.frac}) << up;
    assign small_field = (small_op.exp == '0) ? '0
                                              : (fw'({1'b1, small_op.frac}) << up) >> exp_diff;
    assign mag_sum     = (big.sign ^ small_op.sign) ? {1'b0, big_field} - {1'b0, small_field}
                                                    : {1'b0, big_field} + {1'b0, small_field};

    always_comb begin
        lzc = lw'(fw);
        for (int i = 0; i < fw; i++) begin
            if (mag_sum[i]) begin
                lzc = lw'(fw - 1 - i);   // highest set bit wins
            end
        end
    end

    assign norm = mag_sum[fw-1:0] << lzc;

    always_comb begin
        underflow = 1'b0;
        if (mag_sum[fw]) begin
            exp_norm  = {1'b0, big.exp} + xw'(1);
            frac_norm = mag_sum[fw-1 -: nf];
        end else begin
            exp_norm  = {1'b0, big.exp} - xw'(lzc);
            underflow = xw'(lzc) >= {1'b0, big.exp};
            frac_norm = norm[fw-2 -: nf];
        end
        sum_result = '0;
        if (a_zero && !b_zero) begin
            sum_result = b_eff;
        end else if (b_zero && !a_zero) begin
            sum_result = a;
        end else if (mag_sum == '0) begin
            sum_result = '0;                     // exact cancellation is +0
        end else if (underflow) begin
            sum_result.sign = big.sign;
        end else if (exp_norm >= xw'(fp_alu_pkg::exp_max)) begin
            sum_result.sign = big.sign;          // infinity
            sum_result.exp  = ew'(fp_alu_pkg::exp_max);
        end else begin
            sum_result = {big.sign, exp_norm[ew-1:0], frac_norm};
        end
    end

endmodule

// ==== logic/fp_alu_ctrl.sv ====
module fp_alu_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  fp_alu_pkg::alu_req_t in_req,
    input  logic                 out_ready,
    input  fp_alu_pkg::fp_word_t sum_result,
    input  fp_alu_pkg::fp_word_t mul_result,
    input  fp_alu_pkg::fp_word_t min_result,
    input  fp_alu_pkg::fp_word_t max_result,
    input  logic                 mul_done,
    output logic                 in_ready,
    output logic                 out_valid,
    output fp_alu_pkg::fp_word_t out_result,
    output fp_alu_pkg::fp_word_t a,
    output fp_alu_pkg::fp_word_t b,
    output logic                 subtract,
    output logic                 mul_start
);

    fp_alu_pkg::ctrl_state_e state;
    fp_alu_pkg::alu_op_e     op_q;
    fp_alu_pkg::fp_word_t    comb_result;
    logic                    accept;
    logic                    is_mul;

    assign out_valid = (state == fp_alu_pkg::st_hold);
    assign in_ready  = (state == fp_alu_pkg::st_idle) || (out_valid && out_ready); // accept on consume
    assign accept    = in_valid && in_ready;
    assign is_mul    = (op_q == fp_alu_pkg::op_mul);
    assign subtract  = (op_q == fp_alu_pkg::op_sub);
    assign mul_start = (state == fp_alu_pkg::st_exec) && is_mul;   // single cycle, exec lasts one

    always_comb begin
        case (op_q)
            fp_alu_pkg::op_add,
            fp_alu_pkg::op_sub:  comb_result = sum_result;
            fp_alu_pkg::op_min:  comb_result = min_result;
            fp_alu_pkg::op_max:  comb_result = max_result;
            fp_alu_pkg::op_pass: comb_result = a;
            default:             comb_result = '0;   // unused codes give +0
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fp_alu_pkg::st_idle;
            op_q  <= fp_alu_pkg::op_add;
        end else begin
            if (accept) begin
                op_q <= in_req.op;
            end
            case (state)
                fp_alu_pkg::st_idle: begin
                    if (accept) begin
                        state <= fp_alu_pkg::st_exec;
                    end
                end
                fp_alu_pkg::st_exec: begin
                    if (is_mul) begin
                        state <= fp_alu_pkg::st_wait_mul;
                    end else begin
                        state <= fp_alu_pkg::st_hold;
                    end
                end
                fp_alu_pkg::st_wait_mul: begin
                    if (mul_done) begin
                        state <= fp_alu_pkg::st_hold;
                    end
                end
                fp_alu_pkg::st_hold: begin
                    if (accept) begin
                        state <= fp_alu_pkg::st_exec;   // back to back request
                    end else if (out_ready) begin
                        state <= fp_alu_pkg::st_idle;
                    end
                end
                default: state <= fp_alu_pkg::st_idle;
            endcase
        end
    end

    // operand and result registers
    always_ff @(posedge clk) begin
        if (accept) begin
            a <= in_req.a;
            b <= in_req.b;
        end
        if (state == fp_alu_pkg::st_exec && !is_mul) begin
            out_result <= comb_result;
        end else if (state == fp_alu_pkg::st_wait_mul && mul_done) begin
            out_result <= mul_result;
        end
    end

endmodule

// ==== logic/fp_alu_pkg.sv ====
package fp_alu_pkg;

    localparam int frac_w   = 23;   // stored fraction bits
    localparam int exp_w    = 8;
    localparam int exp_bias = 127;
    localparam int exp_max  = 255;  // exponent field of infinity
    localparam int sig_w    = 24;   // hidden one plus fraction

    // single precision word, sign on the msb
    typedef struct packed {
        logic              sign;
        logic [exp_w-1:0]  exp;    // biased exponent
        logic [frac_w-1:0] frac;
    } fp_word_t;

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_mul  = 3'd2,
        op_min  = 3'd4,   // codes 3 and 7 are unused and give +0
        op_max  = 3'd5,
        op_pass = 3'd6
    } alu_op_e;

    typedef struct packed {
        alu_op_e  op;
        fp_word_t a;
        fp_word_t b;
    } alu_req_t;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,       // combinational result is captured here
        st_wait_mul,
        st_hold        // result presented until consumed
    } ctrl_state_e;

endpackage

// ==== logic/fp_alu_top.sv ====
module fp_alu_top #(
    parameter int sig_width = fp_alu_pkg::sig_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  fp_alu_pkg::alu_req_t in_req,
    input  logic                 out_ready,
    output logic                 in_ready,
    output logic                 out_valid,
    output fp_alu_pkg::fp_word_t out_result
);

    fp_alu_pkg::fp_word_t a;            // registered operands
    fp_alu_pkg::fp_word_t b;
    fp_alu_pkg::fp_word_t sum_result;
    fp_alu_pkg::fp_word_t mul_result;
    fp_alu_pkg::fp_word_t min_result;
    fp_alu_pkg::fp_word_t max_result;
    logic                 subtract;
    logic                 mul_start;
    logic                 mul_done;

    fp_alu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .out_ready  (out_ready),
        .sum_result (sum_result),
        .mul_result (mul_result),
        .min_result (min_result),
        .max_result (max_result),
        .mul_done   (mul_done),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .a          (a),
        .b          (b),
        .subtract   (subtract),
        .mul_start  (mul_start)
    );

    fp_add_sub #(.sig_width(sig_width)) u_add_sub (
        .a          (a),
        .b          (b),
        .subtract   (subtract),
        .sum_result (sum_result)
    );

    fp_mul #(.sig_width(sig_width)) u_mul (
        .clk        (clk),
        .rst        (rst),
        .mul_start  (mul_start),
        .a          (a),
        .b          (b),
        .mul_done   (mul_done),
        .mul_result (mul_result)
    );

    fp_compare u_compare (
        .a          (a),
        .b          (b),
        .min_result (min_result),
        .max_result (max_result)
    );

endmodule

// ==== logic/fp_compare.sv ====
module fp_compare (
    input  fp_alu_pkg::fp_word_t a,
    input  fp_alu_pkg::fp_word_t b,
    output fp_alu_pkg::fp_word_t min_result,
    output fp_alu_pkg::fp_word_t max_result
);

    localparam int mw = fp_alu_pkg::exp_w + fp_alu_pkg::frac_w;

    logic [mw-1:0] mag_a;   // zero exponent reads as zero
    logic [mw-1:0] mag_b;
    logic          a_less;
    logic          b_less;

    assign mag_a = (a.exp == '0) ? '0 : {a.exp, a.frac};
    assign mag_b = (b.exp == '0) ? '0 : {b.exp, b.frac};

    always_comb begin
        if (mag_a == '0 && mag_b == '0) begin
            a_less = 1'b0;              // +0 and -0 tie
            b_less = 1'b0;
        end else if (a.sign != b.sign) begin
            a_less = a.sign;
            b_less = b.sign;
        end else if (a.sign) begin
            a_less = mag_a > mag_b;     // negatives order the other way
            b_less = mag_b > mag_a;
        end else begin
            a_less = mag_a < mag_b;
            b_less = mag_b < mag_a;
        end
    end

    assign min_result = b_less ? b : a;
    assign max_result = a_less ? b : a;

endmodule

// ==== logic/fp_mul.sv ====
module fp_mul #(
    parameter int sig_width = fp_alu_pkg::sig_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mul_start,
    input  fp_alu_pkg::fp_word_t a,
    input  fp_alu_pkg::fp_word_t b,
    output logic                 mul_done,
    output fp_alu_pkg::fp_word_t mul_result
);

    localparam int pw = 2 * sig_width;           // product width
    localparam int cw = $clog2(sig_width + 1);
    localparam int ew = fp_alu_pkg::exp_w;
    localparam int nf = fp_alu_pkg::frac_w;
    localparam int xw = ew + 2;                  // signed exponent, room for both ends
    localparam int up = sig_width - nf - 1;

    logic                 busy;
    logic                 last;
    logic [cw-1:0]        cnt;
    logic [pw-1:0]        mcand;
    logic [sig_width-1:0] mplier;
    logic [pw-1:0]        prod;
    logic                 sign_q;
    logic                 zero_q;
    logic signed [xw-1:0] exp_q;
    logic signed [xw-1:0] exp_fin;
    logic [nf-1:0]        frac_fin;
    fp_alu_pkg::fp_word_t result_d;

    assign last = busy && (cnt == cw'(sig_width));   // finishing cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= last;
            if (!busy && mul_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + cw'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && mul_start) begin
            mcand  <= pw'({1'b1, a.frac}) << up;
            mplier <= sig_width'({1'b1, b.frac}) << up;
            prod   <= '0;
            sign_q <= a.sign ^ b.sign;
            zero_q <= (a.exp == '0) || (b.exp == '0);
            exp_q  <= $signed(xw'(a.exp)) + $signed(xw'(b.exp)) - xw'(fp_alu_pkg::exp_bias);
        end else if (busy && !last) begin
            if (mplier[0]) begin
                prod <= prod + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
        if (last) begin
            mul_result <= result_d;
        end
    end

    // product lies in [1,4), top bit set means one step right
    always_comb begin
        if (prod[pw-1]) begin
            exp_fin  = exp_q + xw'(1);
            frac_fin = prod[pw-2 -: nf];
        end else begin
            exp_fin  = exp_q;
            frac_fin = prod[pw-3 -: nf];
        end
        result_d      = '0;
        result_d.sign = sign_q;
        if (zero_q || exp_fin <= xw'(0)) begin
            result_d.exp = '0;                   // signed zero
        end else if (exp_fin >= xw'(fp_alu_pkg::exp_max)) begin
            result_d.exp = ew'(fp_alu_pkg::exp_max);
        end else begin
            result_d.exp  = exp_fin[ew-1:0];
            result_d.frac = frac_fin;
        end
    end

endmodule

// ==== testbench/tb_fp_alu_vectors.svh ====
// columns: opcode, operand a, operand b, expected result, hold out_ready low
typedef struct packed {
    fp_alu_pkg::alu_op_e  op;
    fp_alu_pkg::fp_word_t a;
    fp_alu_pkg::fp_word_t b;
    fp_alu_pkg::fp_word_t expected;
    logic                 stall;
} vector_t;

localparam int n_vectors = 30;

vector_t vectors [n_vectors];

task automatic load_vectors;
    vectors[0]  = {fp_alu_pkg::op_add,  32'h3f800000, 32'h40000000, 32'h40400000, 1'b0};
    vectors[1]  = {fp_alu_pkg::op_add,  32'h3fc00000, 32'h3fc00000, 32'h40400000, 1'b0}; // carry
    vectors[2]  = {fp_alu_pkg::op_add,  32'h40400000, 32'hbf800000, 32'h40000000, 1'b1};
    vectors[3]  = {fp_alu_pkg::op_sub,  32'h40a00000, 32'h40400000, 32'h40000000, 1'b0};
    vectors[4]  = {fp_alu_pkg::op_sub,  32'h3f800000, 32'h40400000, 32'hc0000000, 1'b0};
    vectors[5]  = {fp_alu_pkg::op_add,  32'hbfc00000, 32'hc0200000, 32'hc0800000, 1'b0};
    vectors[6]  = {fp_alu_pkg::op_sub,  32'h3fa00000, 32'h3f800000, 32'h3e800000, 1'b0};
    vectors[7]  = {fp_alu_pkg::op_add,  32'h3f800000, 32'h33800000, 32'h3f800000, 1'b0}; // 2^-24 lost
    vectors[8]  = {fp_alu_pkg::op_sub,  32'h40200000, 32'h40200000, 32'h00000000, 1'b1};
    vectors[9]  = {fp_alu_pkg::op_add,  32'hc0400000, 32'h40400000, 32'h00000000, 1'b0};
    vectors[10] = {fp_alu_pkg::op_add,  32'h00000000, 32'h40a00000, 32'h40a00000, 1'b0};
    vectors[11] = {fp_alu_pkg::op_sub,  32'h00000000, 32'h40a00000, 32'hc0a00000, 1'b0};
    vectors[12] = {fp_alu_pkg::op_add,  32'h40c00000, 32'h80000000, 32'h40c00000, 1'b0};
    vectors[13] = {fp_alu_pkg::op_mul,  32'h40000000, 32'h40400000, 32'h40c00000, 1'b0};
    vectors[14] = {fp_alu_pkg::op_mul,  32'h3fc00000, 32'h3fc00000, 32'h40100000, 1'b1}; // 2.25
    vectors[15] = {fp_alu_pkg::op_mul,  32'hc0000000, 32'h40400000, 32'hc0c00000, 1'b0};
    vectors[16] = {fp_alu_pkg::op_mul,  32'h3f800001, 32'h3f800001, 32'h3f800002, 1'b0};
    vectors[17] = {fp_alu_pkg::op_mul,  32'hff000000, 32'h40000000, 32'hff800000, 1'b0};
    vectors[18] = {fp_alu_pkg::op_mul,  32'h80800000, 32'h3f000000, 32'h80000000, 1'b0};
    vectors[19] = {fp_alu_pkg::op_min,  32'hbf800000, 32'h40000000, 32'hbf800000, 1'b0};
    vectors[20] = {fp_alu_pkg::op_max,  32'hbf800000, 32'h40000000, 32'h40000000, 1'b0};
    vectors[21] = {fp_alu_pkg::op_min,  32'h40400000, 32'h40000000, 32'h40000000, 1'b0};
    vectors[22] = {fp_alu_pkg::op_max,  32'hc0400000, 32'hc0000000, 32'hc0000000, 1'b1};
    vectors[23] = {fp_alu_pkg::op_min,  32'hc0400000, 32'hc0000000, 32'hc0400000, 1'b0};
    vectors[24] = {fp_alu_pkg::op_min,  32'h00000000, 32'h80000000, 32'h00000000, 1'b0};
    vectors[25] = {fp_alu_pkg::op_max,  32'h80000000, 32'h00000000, 32'h80000000, 1'b0};
    vectors[26] = {fp_alu_pkg::op_max,  32'h40200000, 32'h40200000, 32'h40200000, 1'b0};
    vectors[27] = {fp_alu_pkg::op_pass, 32'h40e00000, 32'h41000000, 32'h40e00000, 1'b0};
    vectors[28] = {3'd3,                32'h40e00000, 32'h41000000, 32'h00000000, 1'b0};
    vectors[29] = {3'd7,                32'h40e00000, 32'h41000000, 32'h00000000, 1'b1};
endtask

// ==== testbench/tb_fp_alu.sv ====
module tb_fp_alu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int max_stall    = 6;    // most cycles out_ready is held low
    localparam int exec_latency = 2;    // acceptance cycle to result cycle

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    fp_alu_pkg::alu_req_t in_req;
    logic                 out_ready;
    logic                 in_ready;
    logic                 out_valid;
    fp_alu_pkg::fp_word_t out_result;

    int cycle_count = 0;
    int error_count = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int seed        = 32'hb01e_f528;

    `include "tb_fp_alu_vectors.svh"

    int accept_cycle [n_vectors];   // cycle in which each request was taken

    fp_alu_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // budget per vector covers the multiplier, back-pressure and handshake slack
    initial begin
        repeat (reset_cycles + n_vectors * (fp_alu_pkg::sig_w + 2 + max_stall + 8)) begin
            @(posedge clk);
        end
        $display("run timed out before all results came back");
        $display("Checks failed");
        $finish;
    end

    function automatic string op_label(input fp_alu_pkg::alu_op_e op);
        case (op)
            fp_alu_pkg::op_add:  return "add";
            fp_alu_pkg::op_sub:  return "sub";
            fp_alu_pkg::op_mul:  return "mul";
            fp_alu_pkg::op_min:  return "min";
            fp_alu_pkg::op_max:  return "max";
            fp_alu_pkg::op_pass: return "pass";
            default:             return "unused";
        endcase
    endfunction

    task automatic check_word(input int index, input fp_alu_pkg::fp_word_t actual,
                              input fp_alu_pkg::fp_word_t expected);
        if (actual !== expected) begin
            $display("Mismatch test %0d out_result: got %h, expected %h", index, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_latency(input int index, input int measured);
        if (measured > exec_latency) begin
            $display("test %0d: result arrived late, after %0d cycles instead of %0d",
                     index, measured, exec_latency);
            error_count++;
        end else if (measured < exec_latency) begin
            $display("test %0d: result arrived early, after %0d cycles instead of %0d",
                     index, measured, exec_latency);
            error_count++;
        end
    endtask

    // in_ready is sampled mid cycle, the request is taken on the next edge
    task automatic drive_requests;
        logic taken;
        for (int i = 0; i < n_vectors; i++) begin
            in_valid = 1'b1;
            in_req   = {vectors[i].op, vectors[i].a, vectors[i].b};
            taken    = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken           = in_ready;
                accept_cycle[i] = cycle_count;
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
        in_req   = '0;
    endtask

    task automatic collect_results;
        int                   errors_before;
        int                   stall_cycles;
        int                   valid_cycle;
        fp_alu_pkg::fp_word_t held;
        for (int i = 0; i < n_vectors; i++) begin
            errors_before = error_count;
            out_ready     = !vectors[i].stall;
            @(negedge clk);
            while (!out_valid) begin
                @(negedge clk);
            end
            valid_cycle = cycle_count;
            if (vectors[i].stall) begin
                held         = out_result;
                stall_cycles = 1 + ($unsigned($random(seed)) % max_stall);
                repeat (stall_cycles) begin
                    @(negedge clk);
                    if (!out_valid || out_result !== held) begin
                        $display("test %0d: result changed while out_ready was low", i);
                        error_count++;
                    end
                    if (in_ready) begin
                        $display("test %0d: a new request could enter while the result was held", i);
                        error_count++;
                    end
                end
                @(posedge clk);
                #1;
                out_ready = 1'b1;
                @(negedge clk);
            end
            if (vectors[i].op != fp_alu_pkg::op_mul) begin
                check_latency(i, valid_cycle - accept_cycle[i]);
            end
            check_word(i, out_result, vectors[i].expected);
            if (error_count == errors_before) begin
                pass_count++;
                $display("test %0d %s: ok", i, op_label(vectors[i].op));
            end else begin
                fail_count++;
                $display("test %0d %s: wrong", i, op_label(vectors[i].op));
            end
            @(posedge clk);   // result consumed on this edge
            #1;
        end
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        load_vectors();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            drive_requests();
            collect_results();
        join
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
